//--- rsp_order_pkg.sv
// Shared widths and channel packets; every request is one line and tags ride in the low mdata bits
package rsp_order_pkg;

    // ================================================
    // Sizing
    // ================================================

    // Outstanding requests tracked per channel
    localparam int MAX_ACTIVE_REQS = 128;
    localparam int TAG_WIDTH = $clog2(MAX_ACTIVE_REQS);

    // Requests the AFU may still issue once almost-full is visible
    localparam int ALM_FULL_THRESHOLD = 8;

    // One extra heap entry absorbs the cycle lost in the registered not-full
    localparam int HEAP_MIN_FREE = ALM_FULL_THRESHOLD + 1;

    // The ROB keeps a deeper reserve because slots drain only in order
    localparam int ROB_MIN_FREE = 2 * ALM_FULL_THRESHOLD;

    // Line data is narrowed for simulation
    localparam int MDATA_WIDTH = 16;
    localparam int DATA_WIDTH = 64;
    localparam int ADDR_WIDTH = 32;

    // ================================================
    // Plain vector types
    // ================================================

    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [MDATA_WIDTH-1:0] mdata_t;
    typedef logic [DATA_WIDTH-1:0] line_data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Occupancy and free counts need one bit more than a tag to reach the full size
    typedef logic [TAG_WIDTH:0] count_t;

    // ================================================
    // Channel packets
    // ================================================

    // Read request toward the fabric
    typedef struct packed {
        logic valid;
        addr_t addr;
        mdata_t mdata;
    } c0_tx_t;

    // Read response toward the AFU
    typedef struct packed {
        logic valid;
        mdata_t mdata;
        line_data_t data;
    } c0_rx_t;

    // Write request toward the fabric
    typedef struct packed {
        logic valid;
        addr_t addr;
        line_data_t data;
        mdata_t mdata;
    } c1_tx_t;

    // Write response toward the AFU
    typedef struct packed {
        logic valid;
        mdata_t mdata;
    } c1_rx_t;

endpackage

//--- mdata_heap.sv
// Tag heap for writes; the caller must free each tag exactly once and stop allocating when not_full drops
`timescale 1ns/1ps

module mdata_heap import rsp_order_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // Allocation side, driven by write requests
    input  logic   alloc,
    input  mdata_t alloc_mdata,
    output tag_t   alloc_tag,

    // Lookup side, driven by write responses, which also frees the tag
    input  logic   lookup,
    input  tag_t   lookup_tag,
    output mdata_t lookup_mdata,

    // Combinational view of the next free count against the reserve
    output logic   not_full
);

    // ================================================
    // Free list
    // ================================================

    // Circular FIFO of free tags, holding every tag after reset
    tag_t free_list [MAX_ACTIVE_REQS];
    tag_t pop_ptr;
    tag_t push_ptr;

    // Number of tags currently in the free list
    count_t num_free;
    count_t num_free_next;

    // Saved AFU mdata, indexed by tag
    mdata_t mdata_mem [MAX_ACTIVE_REQS];

    // First lookup stage holds the tag being read
    tag_t lookup_idx;

    // The head of the free list is the next tag handed out
    assign alloc_tag = free_list[pop_ptr];

    always_comb
    begin
        num_free_next = num_free + count_t'(lookup) - count_t'(alloc);
    end

    // Looking at the next count lets a single register in the top cover the reserve
    assign not_full = (num_free_next >= count_t'(HEAP_MIN_FREE));

    // Pointers and count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pop_ptr <= '0;
            push_ptr <= '0;
            num_free <= count_t'(MAX_ACTIVE_REQS);
        end
        else
        begin
            // Pointers wrap on their own since the depth is a power of two
            if (alloc)
            begin
                pop_ptr <= pop_ptr + 1'b1;
            end
            if (lookup)
            begin
                push_ptr <= push_ptr + 1'b1;
            end
            num_free <= num_free_next;
        end
    end

    // The free list is loaded with every tag in reset and then refilled by frees
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < MAX_ACTIVE_REQS; i++)
            begin
                free_list[i] <= tag_t'(i);
            end
        end
        else if (lookup)
        begin
            free_list[push_ptr] <= lookup_tag;
        end
    end

    // ================================================
    // Mdata store and two-stage lookup
    // ================================================

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            mdata_mem[alloc_tag] <= alloc_mdata;
        end
    end

    // A freed tag goes to the tail of the list, so its entry survives the read below
    always_ff @(posedge clk)
    begin
        lookup_idx <= lookup_tag;
        lookup_mdata <= mdata_mem[lookup_idx];
    end

endmodule

//--- read_rob.sv
// Read reorder buffer; every fill must name an allocated slot and each slot is filled exactly once
`timescale 1ns/1ps

module read_rob import rsp_order_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Allocation in request order
    input  logic       alloc,
    input  mdata_t     alloc_mdata,
    output tag_t       alloc_tag,

    // Fills arrive in any order, tagged with the slot
    input  logic       fill,
    input  tag_t       fill_tag,
    input  line_data_t fill_data,

    // Combinational view of the next occupancy against the reserve
    output logic       not_full,

    // In-order release toward the AFU
    output c0_rx_t     rsp
);

    // ================================================
    // Slot bookkeeping
    // ================================================

    // Tail is the next slot handed out, head the oldest outstanding one
    tag_t tail;
    tag_t head;

    // Occupied slots, counting from allocation to dequeue
    count_t occupied;
    count_t occupied_next;
    count_t free_next;

    // One bit per slot, set once its data has landed
    logic [MAX_ACTIVE_REQS-1:0] filled;

    // Head is ready to leave this cycle
    logic deq;

    // Release pipeline
    tag_t rd_idx;
    logic deq_q;
    logic rsp_valid;
    mdata_t rsp_mdata;
    line_data_t rsp_data;

    // Slot storage
    mdata_t meta_mem [MAX_ACTIVE_REQS];
    line_data_t data_mem [MAX_ACTIVE_REQS];

    // Slots are handed out strictly in order
    assign alloc_tag = tail;

    // A stale filled bit from the previous lap must not release an empty ROB
    assign deq = filled[head] && (occupied != '0);

    always_comb
    begin
        occupied_next = occupied + count_t'(alloc) - count_t'(deq);
        free_next = count_t'(MAX_ACTIVE_REQS) - occupied_next;
    end

    assign not_full = (free_next >= count_t'(ROB_MIN_FREE));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail <= '0;
            head <= '0;
            occupied <= '0;
            filled <= '0;
        end
        else
        begin
            if (alloc)
            begin
                tail <= tail + 1'b1;
                filled[tail] <= 1'b0;
            end
            // Fill never targets the slot being allocated, as that slot is free
            if (fill)
            begin
                filled[fill_tag] <= 1'b1;
            end
            if (deq)
            begin
                head <= head + 1'b1;
            end
            occupied <= occupied_next;
        end
    end

    // ================================================
    // Storage writes
    // ================================================

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            meta_mem[tail] <= alloc_mdata;
        end
        if (fill)
        begin
            data_mem[fill_tag] <= fill_data;
        end
    end

    // ================================================
    // Release pipeline
    // ================================================

    // The dequeued index is registered first and the memories are read one edge later
    always_ff @(posedge clk)
    begin
        rd_idx <= head;
        rsp_mdata <= meta_mem[rd_idx];
        rsp_data <= data_mem[rd_idx];
    end

    // Valid follows the same two stages as the payload
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            deq_q <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            deq_q <= deq;
            rsp_valid <= deq_q;
        end
    end

    // Back-to-back dequeues stream one release per cycle
    assign rsp = '{valid: rsp_valid, mdata: rsp_mdata, data: rsp_data};

endmodule

//--- rsp_order_shim.sv
// Response ordering shim; the fabric must echo each tag once and the AFU must honour almost-full
`timescale 1ns/1ps

module rsp_order_shim import rsp_order_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    // AFU side
    input  c0_tx_t afu_c0_tx,
    input  c1_tx_t afu_c1_tx,
    output c0_rx_t afu_c0_rx,
    output c1_rx_t afu_c1_rx,
    output logic   afu_c0_alm_full,
    output logic   afu_c1_alm_full,

    // Fabric side
    output c0_tx_t fiu_c0_tx,
    output c1_tx_t fiu_c1_tx,
    input  c0_rx_t fiu_c0_rx,
    input  c1_rx_t fiu_c1_rx,
    input  logic   fiu_c0_alm_full,
    input  logic   fiu_c1_alm_full
);

    // ROB links
    tag_t rd_alloc_tag;
    logic rd_not_full;
    logic rd_not_full_q;

    // Heap links
    tag_t wr_alloc_tag;
    mdata_t wr_lookup_mdata;
    logic wr_not_full;
    logic wr_not_full_q;

    // Write response valid, delayed to meet the heap lookup
    logic wr_rsp_valid_q1;
    logic wr_rsp_valid_q2;

    // ================================================
    // Channel 0 (read)
    // ================================================

    // The ROB slot doubles as the fabric tag, so read responses can land directly
    read_rob rd_rob_i
    (
        .clk,
        .reset,
        .alloc(afu_c0_tx.valid),
        .alloc_mdata(afu_c0_tx.mdata),
        .alloc_tag(rd_alloc_tag),
        .fill(fiu_c0_rx.valid),
        .fill_tag(tag_t'(fiu_c0_rx.mdata)),
        .fill_data(fiu_c0_rx.data),
        .not_full(rd_not_full),
        .rsp(afu_c0_rx)
    );

    // Address passes unchanged and the slot tag replaces mdata with zero upper bits
    always_comb
    begin
        fiu_c0_tx = afu_c0_tx;
        fiu_c0_tx.mdata = mdata_t'(rd_alloc_tag);
    end

    // ================================================
    // Channel 1 (write)
    // ================================================

    // Writes complete in fabric order, so a heap of saved mdata is enough
    mdata_heap wr_heap_i
    (
        .clk,
        .reset,
        .alloc(afu_c1_tx.valid),
        .alloc_mdata(afu_c1_tx.mdata),
        .alloc_tag(wr_alloc_tag),
        .lookup(fiu_c1_rx.valid),
        .lookup_tag(tag_t'(fiu_c1_rx.mdata)),
        .lookup_mdata(wr_lookup_mdata),
        .not_full(wr_not_full)
    );

    // Address and data pass unchanged and the heap tag replaces mdata
    always_comb
    begin
        fiu_c1_tx = afu_c1_tx;
        fiu_c1_tx.mdata = mdata_t'(wr_alloc_tag);
    end

    // The heap answers two cycles after the lookup so the valid strobe waits as long
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_rsp_valid_q1 <= 1'b0;
            wr_rsp_valid_q2 <= 1'b0;
        end
        else
        begin
            wr_rsp_valid_q1 <= fiu_c1_rx.valid;
            wr_rsp_valid_q2 <= wr_rsp_valid_q1;
        end
    end

    // Restored mdata rides with the delayed strobe
    always_comb
    begin
        afu_c1_rx.valid = wr_rsp_valid_q2;
        afu_c1_rx.mdata = wr_lookup_mdata;
    end

    // ================================================
    // Almost-full
    // ================================================

    // Registered for timing, and the extra reserve in each block absorbs this cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_not_full_q <= 1'b1;
            wr_not_full_q <= 1'b1;
        end
        else
        begin
            rd_not_full_q <= rd_not_full;
            wr_not_full_q <= wr_not_full;
        end
    end

    // The fabric's own almost-full passes through in the same cycle
    assign afu_c0_alm_full = fiu_c0_alm_full || !rd_not_full_q;
    assign afu_c1_alm_full = fiu_c1_alm_full || !wr_not_full_q;

endmodule

//--- tb_rsp_order_shim.sv
// Self-checking testbench; the fabric model answers each tag once, out of order, after a random delay
`timescale 1ns/1ps

module tb_rsp_order_shim
    import rsp_order_pkg::*;
();

    // ================================================
    // Run limits and data rule
    // ================================================

    localparam int NUM_REQS = 2000;
    localparam int RUN_LIMIT = 40000;
    localparam int DRAIN_LIMIT = 5000;
    localparam int QUIET_TAIL = 20;
    localparam line_data_t DATA_MASK = 64'hA5A5_0000_5A5A_0000;

    // Requests parked at the fabric carry the cycle on which they may be answered
    typedef struct packed {
        tag_t tag;
        addr_t addr;
        logic [31:0] due;
    } pend_t;

    // Reads as the AFU issued them are kept in issue order
    typedef struct packed {
        mdata_t mdata;
        addr_t addr;
    } rd_exp_t;

    logic clk = 1'b0;
    logic reset;
    c0_tx_t afu_c0_tx;
    c1_tx_t afu_c1_tx;
    c0_rx_t afu_c0_rx;
    c1_rx_t afu_c1_rx;
    logic afu_c0_alm_full;
    logic afu_c1_alm_full;
    c0_tx_t fiu_c0_tx;
    c1_tx_t fiu_c1_tx;
    c0_rx_t fiu_c0_rx;
    c1_rx_t fiu_c1_rx;
    logic fiu_c0_alm_full;
    logic fiu_c1_alm_full;

    // Scoreboard and fabric state belong to the main process only
    pend_t rd_pend [$];
    pend_t wr_pend [$];
    rd_exp_t rd_exp [$];
    mdata_t wr_saved [MAX_ACTIVE_REQS];
    logic rd_busy [MAX_ACTIVE_REQS];
    logic wr_busy [MAX_ACTIVE_REQS];
    c1_rx_t wr_exp_s1;
    c1_rx_t wr_exp_s2;
    int unsigned cycle = 0;
    int rd_issued = 0;
    int wr_issued = 0;
    int rd_alm_issues = 0;
    int wr_alm_issues = 0;
    logic rd_alm_seen = 1'b0;
    logic wr_alm_seen = 1'b0;

    always #50 clk = ~clk;

    rsp_order_shim dut_i
    (
        .clk,
        .reset,
        .afu_c0_tx,
        .afu_c1_tx,
        .afu_c0_rx,
        .afu_c1_rx,
        .afu_c0_alm_full,
        .afu_c1_alm_full,
        .fiu_c0_tx,
        .fiu_c1_tx,
        .fiu_c0_rx,
        .fiu_c1_rx,
        .fiu_c0_alm_full,
        .fiu_c1_alm_full
    );

    // ================================================
    // Reference rules and failure path
    // ================================================

    function automatic line_data_t line_for_addr(input addr_t addr);
        return line_data_t'(addr) ^ DATA_MASK;
    endfunction

    task automatic abort_run(input string cause);
        $display("%s", cause);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on the first failure");
    endtask

    // Between request 600 and 1000 the fabric holds responses long enough to fill the storage
    function automatic logic slow_phase();
        return (rd_issued + wr_issued >= 600) && (rd_issued + wr_issued < 1000);
    endfunction

    // Picks one due entry at random, so answers leave in any order
    function automatic int pick_due(input pend_t q[$]);
        int due_idx [$];
        for (int i = 0; i < q.size(); i++)
        begin
            if (q[i].due <= cycle)
            begin
                due_idx.push_back(i);
            end
        end
        if (due_idx.size() == 0)
        begin
            return -1;
        end
        return due_idx[$urandom_range(due_idx.size() - 1)];
    endfunction

    function automatic logic work_left();
        return (rd_exp.size() != 0) || (rd_pend.size() != 0) || (wr_pend.size() != 0)
            || wr_exp_s1.valid || wr_exp_s2.valid;
    endfunction

    // ================================================
    // Compare tasks
    // ================================================

    task automatic check_read_req(input c0_tx_t act, input c0_tx_t want);
        if ((act.valid !== want.valid) || (want.valid && (act.addr !== want.addr)))
        begin
            abort_run($sformatf("[ERROR] %0t: fabric read req valid %b addr %h, expected %b %h",
                $time, act.valid, act.addr, want.valid, want.addr));
        end
    endtask

    task automatic check_write_req(input c1_tx_t act, input c1_tx_t want);
        if ((act.valid !== want.valid)
            || (want.valid && ((act.addr !== want.addr) || (act.data !== want.data))))
        begin
            abort_run($sformatf("[ERROR] %0t: fabric write req %b %h %h, expected %b %h %h",
                $time, act.valid, act.addr, act.data, want.valid, want.addr, want.data));
        end
    endtask

    // A tag must carry zero upper mdata bits and must not already be outstanding
    task automatic check_tag(input mdata_t field, input logic busy, input string chan);
        if ((field[MDATA_WIDTH-1:TAG_WIDTH] !== '0) || busy)
        begin
            abort_run($sformatf("[ERROR] %0t: %s tag %h is malformed or still outstanding",
                $time, chan, field));
        end
    endtask

    task automatic check_read_rsp(input c0_rx_t act, input c0_rx_t want);
        if ((act.mdata !== want.mdata) || (act.data !== want.data))
        begin
            abort_run($sformatf("[ERROR] %0t: read rsp mdata %h data %h, expected %h %h",
                $time, act.mdata, act.data, want.mdata, want.data));
        end
    endtask

    task automatic check_write_rsp(input c1_rx_t act, input c1_rx_t want);
        if ((act.valid !== want.valid) || (want.valid && (act.mdata !== want.mdata)))
        begin
            abort_run($sformatf("[ERROR] %0t: write rsp valid %b mdata %h, expected %b %h",
                $time, act.valid, act.mdata, want.valid, want.mdata));
        end
    endtask

    // The fabric's almost-full must reach the AFU in the same cycle
    task automatic check_alm(input logic alm, input logic fiu_alm, input string chan);
        if (fiu_alm && (alm !== 1'b1))
        begin
            abort_run($sformatf("[ERROR] %0t: %s almost-full low while the fabric's is high",
                $time, chan));
        end
    endtask

    // ================================================
    // Per-cycle drive and observe
    // ================================================

    task automatic drive_requests(input logic issue);
        c0_tx_t rd;
        c1_tx_t wr;
        rd = '0;
        wr = '0;
        // Each channel stops once it has used its allowance under almost-full
        if (issue && (rd_alm_issues < ALM_FULL_THRESHOLD) && ($urandom_range(99) < 60))
        begin
            rd.valid = 1'b1;
            rd.addr = addr_t'($urandom());
            rd.mdata = mdata_t'($urandom());
            rd_issued++;
        end
        if (issue && (wr_alm_issues < ALM_FULL_THRESHOLD) && ($urandom_range(99) < 60))
        begin
            wr.valid = 1'b1;
            wr.addr = addr_t'($urandom());
            wr.data = {$urandom(), $urandom()};
            wr.mdata = mdata_t'($urandom());
            wr_issued++;
        end
        afu_c0_tx <= rd;
        afu_c1_tx <= wr;
        fiu_c0_alm_full <= ($urandom_range(99) < 4);
        fiu_c1_alm_full <= ($urandom_range(99) < 4);
    endtask

    // At most one answer per channel per cycle
    task automatic drive_fabric();
        c0_rx_t rd;
        c1_rx_t wr;
        int idx;
        rd = '0;
        wr = '0;
        idx = pick_due(rd_pend);
        if (idx >= 0)
        begin
            rd.valid = 1'b1;
            rd.mdata = mdata_t'(rd_pend[idx].tag);
            rd.data = line_for_addr(rd_pend[idx].addr);
            rd_busy[rd_pend[idx].tag] = 1'b0;
            rd_pend.delete(idx);
        end
        idx = pick_due(wr_pend);
        if (idx >= 0)
        begin
            wr.valid = 1'b1;
            wr.mdata = mdata_t'(wr_pend[idx].tag);
            wr_busy[wr_pend[idx].tag] = 1'b0;
            wr_pend.delete(idx);
        end
        fiu_c0_rx <= rd;
        fiu_c1_rx <= wr;
    endtask

    task automatic observe_cycle();
        tag_t tag;
        rd_exp_t oldest;
        c0_rx_t rd_want;
        c1_rx_t wr_cur;
        int unsigned delay;
        delay = 1 + $urandom_range(39) + (slow_phase() ? 200 : 0);
        check_alm(afu_c0_alm_full, fiu_c0_alm_full, "read");
        check_alm(afu_c1_alm_full, fiu_c1_alm_full, "write");
        rd_alm_seen = rd_alm_seen || (afu_c0_alm_full && !fiu_c0_alm_full);
        wr_alm_seen = wr_alm_seen || (afu_c1_alm_full && !fiu_c1_alm_full);
        rd_alm_issues = afu_c0_alm_full ? rd_alm_issues + int'(afu_c0_tx.valid) : 0;
        wr_alm_issues = afu_c1_alm_full ? wr_alm_issues + int'(afu_c1_tx.valid) : 0;

        // Reads leave the shim strictly in issue order
        if (afu_c0_rx.valid === 1'b1)
        begin
            if (rd_exp.size() == 0)
            begin
                abort_run($sformatf("[ERROR] %0t: read response with no read outstanding", $time));
            end
            oldest = rd_exp.pop_front();
            rd_want = '{valid: 1'b1, mdata: oldest.mdata, data: line_for_addr(oldest.addr)};
            check_read_rsp(afu_c0_rx, rd_want);
        end

        // Write answers are checked two cycles after the fabric strobe
        check_write_rsp(afu_c1_rx, wr_exp_s2);
        wr_cur = '0;
        if (fiu_c1_rx.valid)
        begin
            wr_cur.valid = 1'b1;
            wr_cur.mdata = wr_saved[tag_t'(fiu_c1_rx.mdata)];
        end
        wr_exp_s2 = wr_exp_s1;
        wr_exp_s1 = wr_cur;

        check_read_req(fiu_c0_tx, afu_c0_tx);
        if (fiu_c0_tx.valid)
        begin
            tag = tag_t'(fiu_c0_tx.mdata);
            check_tag(fiu_c0_tx.mdata, rd_busy[tag], "read");
            rd_busy[tag] = 1'b1;
            rd_pend.push_back('{tag: tag, addr: fiu_c0_tx.addr, due: cycle + delay});
            rd_exp.push_back('{mdata: afu_c0_tx.mdata, addr: afu_c0_tx.addr});
        end
        check_write_req(fiu_c1_tx, afu_c1_tx);
        if (fiu_c1_tx.valid)
        begin
            tag = tag_t'(fiu_c1_tx.mdata);
            check_tag(fiu_c1_tx.mdata, wr_busy[tag], "write");
            wr_busy[tag] = 1'b1;
            wr_saved[tag] = afu_c1_tx.mdata;
            wr_pend.push_back('{tag: tag, addr: fiu_c1_tx.addr, due: cycle + delay});
        end
    endtask

    // Drive on the rising edge and look at the DUT halfway through the cycle
    task automatic run_cycle(input logic issue);
        @(posedge clk);
        cycle++;
        drive_requests(issue);
        drive_fabric();
        @(negedge clk);
        observe_cycle();
    endtask

    // ================================================
    // Main sequence
    // ================================================

    initial
    begin
        int drain_cycles;
        void'($urandom(32'he3ea));
        reset <= 1'b1;
        afu_c0_tx <= '0;
        afu_c1_tx <= '0;
        fiu_c0_rx <= '0;
        fiu_c1_rx <= '0;
        fiu_c0_alm_full <= 1'b0;
        fiu_c1_alm_full <= 1'b0;
        wr_exp_s1 = '0;
        wr_exp_s2 = '0;
        for (int i = 0; i < MAX_ACTIVE_REQS; i++)
        begin
            rd_busy[i] = 1'b0;
            wr_busy[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Quiet cycles where no response valid may rise
        repeat (5) run_cycle(1'b0);

        while (rd_issued + wr_issued < NUM_REQS)
        begin
            if (cycle > RUN_LIMIT)
            begin
                abort_run("Timeout: the AFU could not issue all requests, almost-full stayed high");
            end
            run_cycle(1'b1);
        end

        // One idle cycle lets the last request reach the scoreboard before draining
        run_cycle(1'b0);
        drain_cycles = 0;
        while (work_left())
        begin
            if (drain_cycles > DRAIN_LIMIT)
            begin
                abort_run("Timeout: responses were still outstanding after the drain limit");
            end
            run_cycle(1'b0);
            drain_cycles++;
        end

        // Any response valid after the drain would answer a request a second time
        repeat (QUIET_TAIL) run_cycle(1'b0);

        if (!rd_alm_seen || !wr_alm_seen)
        begin
            abort_run("Almost-full from the shim's own storage never rose during the slow burst");
        end
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- rsp_order_shim.f
rsp_order_pkg.sv
mdata_heap.sv
read_rob.sv
rsp_order_shim.sv
tb_rsp_order_shim.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status reports pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_rsp_order_shim \
    -f rsp_order_shim.f \
    -o sim_tb_rsp_order_shim \
    && ./obj_dir/sim_tb_rsp_order_shim \
    || { echo "Simulation build or run failed"; exit 1; }
